//--- source/panel_bus_pkg.sv
`default_nettype none

package panel_bus_pkg;

    ////////////////////
    // Sizes and timing
    localparam int CARD_COUNT       = 4;   // Cards written per command
    localparam int STARTUP_CYCLES   = 100; // Power-up hold length
    localparam int WAIT_UNIT_CYCLES = 22;  // Cycles in one wait unit
    localparam int LINE_MAX         = 32;  // Line buffer depth in bytes
    localparam int CMD_LEN          = 11;  // Command word incl. comma
    localparam int PARAM_BYTES      = 5;   // Address byte plus four data bytes

    ////////////////////
    // Vector types
    typedef logic [7:0] byte_t;       // Character or data byte
    typedef logic [3:0] nibble_t;     // One hex digit
    typedef logic [2:0] bus_addr_t;   // Backplane address
    typedef logic [3:0] card_sel_t;   // One-hot card select
    typedef logic [1:0] card_idx_t;   // Card number 0..3
    typedef logic [2:0] wait_units_t; // Wait length in units
    typedef logic [5:0] line_idx_t;   // Line buffer index

    typedef logic [$clog2(WAIT_UNIT_CYCLES)-1:0] unit_count_t;  // Cycle count inside a unit
    typedef logic [$clog2(STARTUP_CYCLES+1)-1:0] hold_count_t;  // Power-up hold count

    ////////////////////
    // Characters and text
    localparam byte_t        CHAR_CR      = 8'h0D;
    localparam byte_t        CHAR_LF      = 8'h0A;
    localparam byte_t        FAIL_CODE    = 8'h54;          // Code shown in the Failed reply
    localparam logic [87:0]  CMD_WORD     = "pb_i_write,";  // Only accepted command
    localparam logic [63:0]  WRITE_PREFIX = "Write 0x";
    localparam logic [71:0]  FAIL_PREFIX  = "Failed 0x";

    ////////////////////
    // State machines
    typedef enum logic {
        reply_write,
        reply_fail
    } reply_kind_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_wait,           // Count off wait units, then go to the stored next phase
        seq_assert_address,
        seq_assert_data,
        seq_assert_write,
        seq_release_write,
        seq_release_data,
        seq_done
    } sequencer_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_strobe,
        tx_gap
    } transmit_state_t;

endpackage

`default_nettype wire

//--- source/command_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module command_receiver (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,      // Low during the power-up hold
    input  logic                 busy,        // Write or reply in progress
    input  panel_bus_pkg::byte_t rx_data,
    input  logic                 rx_valid,
    output logic                 write_start,
    output logic                 reject,
    output panel_bus_pkg::byte_t addr_byte,
    output panel_bus_pkg::byte_t card_data [panel_bus_pkg::CARD_COUNT]
);

    panel_bus_pkg::byte_t     line_buf [panel_bus_pkg::LINE_MAX]; // Current line, no LF or CR
    panel_bus_pkg::line_idx_t line_idx;                           // Next free slot
    panel_bus_pkg::byte_t     decoded  [panel_bus_pkg::PARAM_BYTES];
    logic                     cmd_match;
    logic                     line_end;
    logic                     line_busy;

    // Hex digit to value, anything else reads as F
    function automatic panel_bus_pkg::nibble_t hex_value(input panel_bus_pkg::byte_t c);
        if (c >= 8'h30 && c <= 8'h39) return panel_bus_pkg::nibble_t'(c - 8'h30);       // 0-9
        else if (c >= 8'h61 && c <= 8'h66) return panel_bus_pkg::nibble_t'(c - 8'h57);  // a-f
        else if (c >= 8'h41 && c <= 8'h46) return panel_bus_pkg::nibble_t'(c - 8'h37);  // A-F
        else return 4'hF;
    endfunction

    assign line_end  = enable && rx_valid && (rx_data == panel_bus_pkg::CHAR_LF);
    assign line_busy = busy || write_start || reject; // Own pulse counts as busy too

    ////////////////////
    // Match and decode
    always_comb begin
        cmd_match = (line_idx >= panel_bus_pkg::line_idx_t'(panel_bus_pkg::CMD_LEN)); // Too short never matches
        for (int i = 0; i < panel_bus_pkg::CMD_LEN; i++) begin
            if (line_buf[i] != panel_bus_pkg::CMD_WORD[8*(panel_bus_pkg::CMD_LEN-1-i) +: 8])
                cmd_match = 1'b0;
        end
        for (int p = 0; p < panel_bus_pkg::PARAM_BYTES; p++) begin
            decoded[p] = {hex_value(line_buf[panel_bus_pkg::CMD_LEN + 2*p]),     // High digit first
                          hex_value(line_buf[panel_bus_pkg::CMD_LEN + 2*p + 1])};
        end
    end

    ////////////////////
    // Line buffer
    always_ff @(posedge clock) begin
        if (enable && rx_valid && rx_data != panel_bus_pkg::CHAR_LF &&
            rx_data != panel_bus_pkg::CHAR_CR &&
            line_idx < panel_bus_pkg::line_idx_t'(panel_bus_pkg::LINE_MAX)) begin
            line_buf[line_idx[4:0]] <= rx_data; // Bytes past the 32nd are dropped
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_idx    <= '0;
            write_start <= 1'b0;
            reject      <= 1'b0;
        end else begin
            write_start <= 1'b0; // Single-cycle pulses
            reject      <= 1'b0;
            if (line_end) begin
                line_idx <= '0;  // Every LF starts a new line
                if (!line_busy) begin
                    write_start <= cmd_match;
                    reject      <= !cmd_match;
                end
            end else if (enable && rx_valid && rx_data != panel_bus_pkg::CHAR_CR &&
                         line_idx < panel_bus_pkg::line_idx_t'(panel_bus_pkg::LINE_MAX)) begin
                line_idx <= line_idx + 1'b1;
            end
        end
    end

    // Decoded fields, held for the sequencer and the reply
    always_ff @(posedge clock) begin
        if (line_end && !line_busy && cmd_match) begin
            addr_byte <= decoded[0];
            for (int k = 0; k < panel_bus_pkg::CARD_COUNT; k++) begin
                card_data[k] <= decoded[k+1]; // Byte 0 is the address
            end
        end
    end

endmodule

`default_nettype wire

//--- source/card_write_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module card_write_sequencer (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write_start,
    input  panel_bus_pkg::byte_t     addr_byte,
    input  panel_bus_pkg::byte_t     card_data [panel_bus_pkg::CARD_COUNT],
    output logic                     busy,
    output logic                     write_done,
    output panel_bus_pkg::byte_t     bus_data,
    output logic                     bus_drive,
    output panel_bus_pkg::bus_addr_t bus_addr,
    output panel_bus_pkg::card_sel_t card_select,
    output logic                     wr_n
);

    panel_bus_pkg::sequencer_state_t state;
    panel_bus_pkg::sequencer_state_t next_state;  // Phase to resume after a wait
    panel_bus_pkg::unit_count_t      unit_count;  // Cycle inside the current unit
    panel_bus_pkg::wait_units_t      remaining;   // Units left in the wait
    panel_bus_pkg::card_idx_t        card_idx;

    localparam panel_bus_pkg::unit_count_t UNIT_LAST =
        panel_bus_pkg::unit_count_t'(panel_bus_pkg::WAIT_UNIT_CYCLES - 1);

    assign busy       = (state != panel_bus_pkg::seq_idle);
    assign write_done = (state == panel_bus_pkg::seq_done);

    // A phase cycle plus its wait spans exactly units x 22 cycles,
    // so the wait counter starts at 1
    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= panel_bus_pkg::seq_idle;
            next_state  <= panel_bus_pkg::seq_idle;
            unit_count  <= '0;
            remaining   <= '0;
            card_idx    <= '0;
            bus_drive   <= 1'b0;
            bus_addr    <= '0;
            card_select <= '0;
            wr_n        <= 1'b1;
        end else begin
            case (state)
                panel_bus_pkg::seq_idle: begin
                    if (write_start) begin
                        card_idx   <= '0;
                        unit_count <= panel_bus_pkg::unit_count_t'(1);
                        remaining  <= 3'd1;                           // Pre-delay
                        next_state <= panel_bus_pkg::seq_assert_address;
                        state      <= panel_bus_pkg::seq_wait;
                    end
                end
                panel_bus_pkg::seq_wait: begin
                    if (unit_count == UNIT_LAST) begin
                        unit_count <= '0;
                        remaining  <= remaining - 1'b1;
                        if (remaining == 3'd1) state <= next_state;  // Last unit ends
                    end else begin
                        unit_count <= unit_count + 1'b1;
                    end
                end
                panel_bus_pkg::seq_assert_address: begin
                    card_select <= panel_bus_pkg::card_sel_t'(1) << card_idx;
                    bus_addr    <= addr_byte[2:0];                    // Low 3 bits only
                    unit_count  <= panel_bus_pkg::unit_count_t'(1);
                    remaining   <= 3'd4;
                    next_state  <= panel_bus_pkg::seq_assert_data;
                    state       <= panel_bus_pkg::seq_wait;
                end
                panel_bus_pkg::seq_assert_data: begin
                    bus_drive  <= 1'b1;                               // Data on the bus
                    unit_count <= panel_bus_pkg::unit_count_t'(1);
                    remaining  <= 3'd1;
                    next_state <= panel_bus_pkg::seq_assert_write;
                    state      <= panel_bus_pkg::seq_wait;
                end
                panel_bus_pkg::seq_assert_write: begin
                    wr_n       <= 1'b0;                               // Active low strobe
                    unit_count <= panel_bus_pkg::unit_count_t'(1);
                    remaining  <= 3'd2;
                    next_state <= panel_bus_pkg::seq_release_write;
                    state      <= panel_bus_pkg::seq_wait;
                end
                panel_bus_pkg::seq_release_write: begin
                    wr_n       <= 1'b1;
                    unit_count <= panel_bus_pkg::unit_count_t'(1);
                    remaining  <= 3'd2;
                    next_state <= panel_bus_pkg::seq_release_data;
                    state      <= panel_bus_pkg::seq_wait;
                end
                panel_bus_pkg::seq_release_data: begin
                    bus_drive  <= 1'b0;
                    card_idx   <= card_idx + 1'b1;                    // Wraps to 0 after card 3
                    unit_count <= panel_bus_pkg::unit_count_t'(1);
                    remaining  <= 3'd1;
                    next_state <= (card_idx == 2'd3) ? panel_bus_pkg::seq_done
                                                     : panel_bus_pkg::seq_assert_address;
                    state      <= panel_bus_pkg::seq_wait;
                end
                default: begin
                    state <= panel_bus_pkg::seq_idle;                 // Done lasts one cycle
                end
            endcase
        end
    end

    // Data byte for the current card
    always_ff @(posedge clock) begin
        if (state == panel_bus_pkg::seq_assert_data) bus_data <= card_data[card_idx];
    end

endmodule

`default_nettype wire

//--- source/reply_transmitter.sv
`timescale 1ns/10ps
`default_nettype none

module reply_transmitter (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       send,
    input  panel_bus_pkg::reply_kind_t kind,
    input  panel_bus_pkg::byte_t       code,
    output logic                       reply_busy,
    output panel_bus_pkg::byte_t       tx_data,
    output logic                       tx_valid
);

    panel_bus_pkg::transmit_state_t state;
    panel_bus_pkg::reply_kind_t     kind_q;      // Latched on send
    panel_bus_pkg::byte_t           code_q;
    logic [3:0]                     char_idx;    // Position in the reply
    logic [3:0]                     prefix_len;
    logic [3:0]                     suffix_idx;  // Position after the prefix
    logic                           last_char;

    // Nibble to upper-case hex character
    function automatic panel_bus_pkg::byte_t hex_char(input panel_bus_pkg::nibble_t value);
        if (value < 4'd10) return 8'h30 + 8'(value);
        else return 8'h37 + 8'(value);  // 10 maps to 'A'
    endfunction

    assign prefix_len = (kind_q == panel_bus_pkg::reply_write) ? 4'd8 : 4'd9;
    assign suffix_idx = char_idx - prefix_len;
    assign last_char  = (suffix_idx == 4'd3);  // LF ends the reply

    always_comb begin
        if (char_idx < prefix_len) begin
            if (kind_q == panel_bus_pkg::reply_write)
                tx_data = panel_bus_pkg::WRITE_PREFIX[8*(7 - char_idx) +: 8];
            else
                tx_data = panel_bus_pkg::FAIL_PREFIX[8*(8 - char_idx) +: 8];
        end else begin
            case (suffix_idx)
                4'd0:    tx_data = hex_char(code_q[7:4]);
                4'd1:    tx_data = hex_char(code_q[3:0]);
                4'd2:    tx_data = panel_bus_pkg::CHAR_CR;
                default: tx_data = panel_bus_pkg::CHAR_LF;
            endcase
        end
    end

    assign tx_valid   = (state == panel_bus_pkg::tx_strobe);
    assign reply_busy = (state != panel_bus_pkg::tx_idle);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= panel_bus_pkg::tx_idle;
            char_idx <= '0;
        end else begin
            case (state)
                panel_bus_pkg::tx_idle: begin
                    char_idx <= '0;
                    if (send) state <= panel_bus_pkg::tx_strobe;
                end
                panel_bus_pkg::tx_strobe: begin
                    char_idx <= char_idx + 1'b1;
                    state    <= last_char ? panel_bus_pkg::tx_idle : panel_bus_pkg::tx_gap;
                end
                default: state <= panel_bus_pkg::tx_strobe;  // One idle cycle between chars
            endcase
        end
    end

    // Reply contents
    always_ff @(posedge clock) begin
        if (state == panel_bus_pkg::tx_idle && send) begin
            kind_q <= kind;
            code_q <= code;
        end
    end

endmodule

`default_nettype wire

//--- source/panel_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module panel_bus_top (
    input  logic                     clock,
    input  logic                     reset,
    input  panel_bus_pkg::byte_t     rx_data,
    input  logic                     rx_valid,
    output panel_bus_pkg::byte_t     tx_data,
    output logic                     tx_valid,
    output panel_bus_pkg::byte_t     bus_data,
    output logic                     bus_drive,           // Drive enable for the data pad
    output panel_bus_pkg::bus_addr_t bus_addr,
    output panel_bus_pkg::card_sel_t card_select,
    output logic                     wr_n,
    output logic                     rd_n,
    output logic                     test_address,
    output logic                     lamp_reset,
    output logic                     level_shift_enable
);

    panel_bus_pkg::hold_count_t hold_count;
    logic                       hold_done;
    logic                       write_start;
    logic                       reject;
    logic                       write_done;
    logic                       seq_busy;
    logic                       reply_busy;
    panel_bus_pkg::byte_t       addr_byte;
    panel_bus_pkg::byte_t       card_data [panel_bus_pkg::CARD_COUNT];

    ////////////////////
    // Power-up hold
    assign hold_done = (hold_count == panel_bus_pkg::hold_count_t'(panel_bus_pkg::STARTUP_CYCLES));

    always_ff @(posedge clock) begin
        if (reset) hold_count <= '0;
        else if (!hold_done) hold_count <= hold_count + 1'b1;  // Stops at the end of the hold
    end

    assign lamp_reset         = !hold_done;
    assign level_shift_enable = hold_done;
    assign rd_n               = 1'b1;  // No read cycles
    assign test_address       = 1'b1;

    ////////////////////
    // Blocks
    command_receiver u_receiver (
        .clock       (clock),
        .reset       (reset),
        .enable      (hold_done),
        .busy        (seq_busy || reply_busy),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .write_start (write_start),
        .reject      (reject),
        .addr_byte   (addr_byte),
        .card_data   (card_data)
    );

    card_write_sequencer u_sequencer (
        .clock       (clock),
        .reset       (reset),
        .write_start (write_start),
        .addr_byte   (addr_byte),
        .card_data   (card_data),
        .busy        (seq_busy),
        .write_done  (write_done),
        .bus_data    (bus_data),
        .bus_drive   (bus_drive),
        .bus_addr    (bus_addr),
        .card_select (card_select),
        .wr_n        (wr_n)
    );

    reply_transmitter u_transmitter (
        .clock      (clock),
        .reset      (reset),
        .send       (write_done || reject),
        .kind       (write_done ? panel_bus_pkg::reply_write : panel_bus_pkg::reply_fail),
        .code       (write_done ? addr_byte : panel_bus_pkg::FAIL_CODE),  // Address echoed on success
        .reply_busy (reply_busy),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;  // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);  // Two reset cycles
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
    input  logic         clock,
    input  logic         reset,
    input  int           line_no,        // Line now in flight
    input  logic         exp_valid,      // Line should give four card writes
    input  logic [7:0]   exp_addr,
    input  logic [31:0]  exp_data,       // Card k in bits 8k+7..8k
    input  logic [103:0] exp_reply,      // First character in the top byte
    input  int           exp_reply_len,
    input  logic [7:0]   tx_data,
    input  logic         tx_valid,
    input  logic [7:0]   bus_data,
    input  logic         bus_drive,
    input  logic [2:0]   bus_addr,
    input  logic [3:0]   card_select,
    input  logic         wr_n,
    input  logic         rd_n,
    input  logic         test_address,
    input  logic         lamp_reset,
    input  logic         level_shift_enable,
    output int           lines_done,
    output int           tests_failed,
    output int           error_count
);

    localparam int HOLD   = panel_bus_pkg::STARTUP_CYCLES;
    localparam int STROBE = 2 * panel_bus_pkg::WAIT_UNIT_CYCLES;  // Two wait units low

    int    cycle;        // Cycles since reset release
    int    test_errors;  // Errors in the current test
    int    pulses;       // wr_n pulses seen for this line
    int    low_cycles;
    int    reply_idx;
    logic  wr_n_prev;
    string name;

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("** Error %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
        error_count++;
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        error_count++;
        test_errors++;
    endtask

    task automatic finish_test(input string what);
        if (test_errors == 0) begin
            $display("%s: ok", what);
        end else begin
            $display("%s: %0d errors", what, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    ////////////////////
    // Power-up hold
    task automatic check_startup();
        if (cycle < HOLD) begin
            if (lamp_reset !== 1'b1) report_mismatch("startup lamp_reset", 1, int'(lamp_reset));
            if (level_shift_enable !== 1'b0)
                report_mismatch("startup level_shift_enable", 0, int'(level_shift_enable));
            if (wr_n !== 1'b1) report_mismatch("startup wr_n", 1, int'(wr_n));
            if (bus_drive !== 1'b0) report_mismatch("startup bus_drive", 0, int'(bus_drive));
            if (rd_n !== 1'b1) report_mismatch("startup rd_n", 1, int'(rd_n));
            if (test_address !== 1'b1)
                report_mismatch("startup test_address", 1, int'(test_address));
            if (card_select !== 4'b0000)
                report_mismatch("startup card_select", 0, int'(card_select));
        end else if (cycle == HOLD) begin
            if (lamp_reset !== 1'b0) report_mismatch("startup end lamp_reset", 0, int'(lamp_reset));
            if (level_shift_enable !== 1'b1)
                report_mismatch("startup end level_shift_enable", 1, int'(level_shift_enable));
            finish_test("startup");
        end else if (lamp_reset !== 1'b0 || level_shift_enable !== 1'b1) begin
            report_problem("lamp_reset or level_shift_enable changed after the hold");
        end
    endtask

    ////////////////////
    // Card write strobes
    task automatic watch_strobe();
        int k;
        k = pulses;
        if (wr_n === 1'b0 && wr_n_prev === 1'b1) begin  // Falling edge of the strobe
            if (!exp_valid || k >= panel_bus_pkg::CARD_COUNT) begin
                report_problem($sformatf("%s: unexpected write strobe number %0d", name, k + 1));
            end else begin
                if (card_select !== 4'(1 << k))
                    report_mismatch($sformatf("%s card %0d select", name, k), 1 << k, card_select);
                if (bus_addr !== exp_addr[2:0])
                    report_mismatch($sformatf("%s card %0d addr", name, k), exp_addr[2:0], bus_addr);
                if (bus_data !== exp_data[8*k +: 8])
                    report_mismatch($sformatf("%s card %0d data", name, k), exp_data[8*k +: 8],
                                    bus_data);
                if (bus_drive !== 1'b1)
                    report_mismatch($sformatf("%s card %0d drive", name, k), 1, int'(bus_drive));
            end
            pulses++;
        end
        if (wr_n === 1'b0) begin
            low_cycles++;
        end else if (wr_n_prev === 1'b0) begin  // Strobe just ended
            if (low_cycles != STROBE)
                report_mismatch($sformatf("%s strobe width", name), STROBE, low_cycles);
            low_cycles = 0;
        end
        wr_n_prev = wr_n;
    endtask

    ////////////////////
    // Reply characters
    task automatic watch_reply();
        logic [7:0] expected;
        if (tx_valid === 1'b1) begin
            expected = exp_reply[8*(12 - reply_idx) +: 8];
            if (tx_data !== expected)
                report_mismatch($sformatf("%s reply char %0d", name, reply_idx), expected, tx_data);
            reply_idx++;
            if (reply_idx == exp_reply_len) begin  // LF seen, line complete
                if (pulses != (exp_valid ? panel_bus_pkg::CARD_COUNT : 0))
                    report_mismatch($sformatf("%s strobe count", name),
                                    exp_valid ? panel_bus_pkg::CARD_COUNT : 0, pulses);
                finish_test(name);
                pulses    = 0;
                reply_idx = 0;
                lines_done++;
            end
        end
    endtask

    always @(posedge clock) begin  // Values of the cycle that just ended
        if (reset) begin
            cycle        = 0;
            lines_done   = 0;
            tests_failed = 0;
            error_count  = 0;
            test_errors  = 0;
            pulses       = 0;
            low_cycles   = 0;
            reply_idx    = 0;
            wr_n_prev    = 1'b1;
        end else begin
            name = $sformatf("line %0d", line_no);
            check_startup();
            watch_strobe();
            watch_reply();
            cycle++;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top;

    localparam int NUM_LINES = 30;
    localparam int LIMIT     = NUM_LINES * (41 * panel_bus_pkg::WAIT_UNIT_CYCLES + 300)
                               + panel_bus_pkg::STARTUP_CYCLES + 1000;  // Worst line plus margin

    logic         clock;
    logic         reset;
    logic [7:0]   rx_data;
    logic         rx_valid;
    logic [7:0]   tx_data;
    logic         tx_valid;
    logic [7:0]   bus_data;
    logic         bus_drive;
    logic [2:0]   bus_addr;
    logic [3:0]   card_select;
    logic         wr_n;
    logic         rd_n;
    logic         test_address;
    logic         lamp_reset;
    logic         level_shift_enable;
    int           line_no;
    logic         exp_valid;
    logic [7:0]   exp_addr;
    logic [31:0]  exp_data;
    logic [103:0] exp_reply;
    int           exp_reply_len;
    int           lines_done;
    int           tests_failed;
    int           error_count;
    int           cycles = 0;
    logic [7:0]   line_chars [$];  // Current line without the LF

    tb_clock u_clock (
        .clock (clock),
        .reset (reset)
    );

    panel_bus_top DUT (
        .clock              (clock),
        .reset              (reset),
        .rx_data            (rx_data),
        .rx_valid           (rx_valid),
        .tx_data            (tx_data),
        .tx_valid           (tx_valid),
        .bus_data           (bus_data),
        .bus_drive          (bus_drive),
        .bus_addr           (bus_addr),
        .card_select        (card_select),
        .wr_n               (wr_n),
        .rd_n               (rd_n),
        .test_address       (test_address),
        .lamp_reset         (lamp_reset),
        .level_shift_enable (level_shift_enable)
    );

    tb_checker u_check (
        .clock              (clock),
        .reset              (reset),
        .line_no            (line_no),
        .exp_valid          (exp_valid),
        .exp_addr           (exp_addr),
        .exp_data           (exp_data),
        .exp_reply          (exp_reply),
        .exp_reply_len      (exp_reply_len),
        .tx_data            (tx_data),
        .tx_valid           (tx_valid),
        .bus_data           (bus_data),
        .bus_drive          (bus_drive),
        .bus_addr           (bus_addr),
        .card_select        (card_select),
        .wr_n               (wr_n),
        .rd_n               (rd_n),
        .test_address       (test_address),
        .lamp_reset         (lamp_reset),
        .level_shift_enable (level_shift_enable),
        .lines_done         (lines_done),
        .tests_failed       (tests_failed),
        .error_count        (error_count)
    );

    ////////////////////
    // Model
    function automatic logic [3:0] nibble_of(input logic [7:0] c);
        if (c >= 8'h30 && c <= 8'h39) return c[3:0];  // Digit value sits in the low nibble
        if ((c >= 8'h61 && c <= 8'h66) || (c >= 8'h41 && c <= 8'h46)) return c[3:0] + 4'd9;
        return 4'hF;                                  // Not hex
    endfunction

    function automatic logic [7:0] random_hex_char();
        logic [7:0] v;
        int         style;
        v     = 8'($urandom_range(0, 15));
        style = $urandom_range(0, 9);
        if (style == 0) return 8'h67 + v;             // g..v, invalid
        if (v < 8'd10) return 8'h30 + v;
        return (style < 5) ? 8'h57 + v : 8'h37 + v;   // Lower or upper case
    endfunction

    task automatic build_line();
        int    kind;
        int    len;
        string word;
        line_chars.delete();
        kind = $urandom_range(0, 7);
        if (kind == 1) begin                          // Random word
            len = $urandom_range(3, 14);
            for (int i = 0; i < len; i++) begin
                line_chars.push_back(8'h61 + 8'($urandom_range(0, 25)));
            end
        end else begin
            if (kind == 0) word = "pb_i__read,";
            else word = "pb_i_write,";
            for (int i = 0; i < word.len(); i++) begin
                line_chars.push_back(word[i]);
            end
            for (int i = 0; i < 10; i++) begin
                line_chars.push_back(random_hex_char());
            end
        end
        if ($urandom_range(0, 3) == 0) line_chars.push_back(8'h0D);  // CR before LF now and then
    endtask

    task automatic model_line();
        logic [7:0] kept [$];
        string      word;
        string      digits;
        logic [7:0] code;
        int         n;
        word   = "pb_i_write,";
        digits = "0123456789ABCDEF";
        foreach (line_chars[i]) begin
            if (line_chars[i] != 8'h0D) kept.push_back(line_chars[i]);  // CR is ignored
        end
        exp_valid = (kept.size() >= 11);
        for (int i = 0; i < 11 && i < kept.size(); i++) begin
            if (kept[i] != 8'(word[i])) exp_valid = 1'b0;
        end
        exp_addr = '0;
        exp_data = '0;
        if (exp_valid) begin
            exp_addr = {nibble_of(kept[11]), nibble_of(kept[12])};
            for (int k = 0; k < 4; k++) begin
                exp_data[8*k +: 8] = {nibble_of(kept[13 + 2*k]), nibble_of(kept[14 + 2*k])};
            end
            word = "Write 0x";
            code = exp_addr;
        end else begin
            word = "Failed 0x";
            code = panel_bus_pkg::FAIL_CODE;
        end
        n         = word.len();
        exp_reply = '0;
        for (int i = 0; i < n; i++) begin
            exp_reply[8*(12 - i) +: 8] = 8'(word[i]);
        end
        exp_reply[8*(12 - n) +: 8]     = 8'(digits[code[7:4]]);
        exp_reply[8*(11 - n) +: 8]     = 8'(digits[code[3:0]]);
        exp_reply[8*(10 - n) +: 8]     = 8'h0D;
        exp_reply[8*(9 - n) +: 8]      = 8'h0A;
        exp_reply_len = n + 4;
    endtask

    ////////////////////
    // Stimulus
    task automatic send_line();
        foreach (line_chars[i]) begin
            @(negedge clock);
            rx_data  = line_chars[i];
            rx_valid = 1'b1;
        end
        @(negedge clock);
        rx_data = 8'h0A;  // LF ends the line
        @(negedge clock);
        rx_valid = 1'b0;
        rx_data  = '0;
    endtask

    initial begin
        void'($urandom(34));
        rx_data       = '0;
        rx_valid      = 1'b0;
        line_no       = 0;
        exp_valid     = 1'b0;
        exp_addr      = '0;
        exp_data      = '0;
        exp_reply     = '0;
        exp_reply_len = 0;
        @(negedge clock);
        while (reset || lamp_reset !== 1'b0) @(negedge clock);  // Wait out the hold
        for (int i = 0; i < NUM_LINES; i++) begin
            line_no = i + 1;
            build_line();
            model_line();
            send_line();
            while (lines_done < i + 1) @(negedge clock);  // Reply finished
        end
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 NUM_LINES + 1, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
source/panel_bus_pkg.sv
source/command_receiver.sv
source/card_write_sequencer.sv
source/reply_transmitter.sv
source/panel_bus_top.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f
	./obj_dir/Vtb_top | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
